// File: Makefile
# Verilator build and run for the npc_core testbench

TB_TOP = npc_core_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -f npc_core.f --top-module $(TB_TOP) -o vsim
	out="$$(./obj_dir/vsim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall -f npc_core.f --top-module npc_core --timing

clean:
	rm -rf obj_dir

// File: bench/npc_core_checker.sv
// compares retirements in order against the queue filled at input acceptance; reset empties it
`timescale 1ns/10ps
`include "npc_settings.svh"

module npc_core_checker import npc_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  int        test_id,
	// input handshake plus the expected fields for that instruction
	input  logic      inst_valid,
	input  logic      inst_ready,
	input  npc_pc_t   exp_pc,
	input  npc_reg_t  exp_rd,
	input  npc_data_t exp_value,
	input  logic      exp_wen,
	input  logic      exp_illegal,
	// retire port
	input  logic      retire_valid,
	input  logic      retire_ready,
	input  npc_pc_t   retire_pc,
	input  npc_reg_t  retire_rd,
	input  npc_data_t retire_value,
	input  logic      retire_wen,
	input  logic      retire_illegal,
	output int        err_count,
	output int        pending
);

	npc_pc_t   q_pc [$];
	npc_reg_t  q_rd [$];
	npc_data_t q_value [$];
	logic      q_wen [$];
	logic      q_illegal [$];
	int        errs = 0;
	int        depth = 0;

	assign err_count = errs;
	assign pending   = depth;

	function string test_name(input int id);
		case (id)
			1:       return "independent_arith";
			2:       return "dependency_chain";
			3:       return "register_zero";
			4:       return "illegal_encoding";
			5:       return "random_backpressure";
			6:       return "reset_midstream";
			default: return "none";
		endcase
	endfunction

	task automatic check_field(input string field, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("FAIL %s %s expected %h actual %h", test_name(test_id), field, exp, act);
			errs++;
		end
	endtask

	// ********************
	// watch both ends
	// ********************

	always @(posedge clk) begin
		if (rst) begin
			// in-flight work is dropped by the core
			q_pc.delete();
			q_rd.delete();
			q_value.delete();
			q_wen.delete();
			q_illegal.delete();
		end else begin
			if (retire_valid && retire_ready) begin
				if (q_pc.size() == 0) begin
					$display("ERROR test %s: instruction at pc %h retired with none expected",
						test_name(test_id), retire_pc);
					errs++;
				end else begin
					check_field("pc", q_pc.pop_front(), retire_pc);
					check_field("rd", 64'(q_rd.pop_front()), 64'(retire_rd));
					check_field("value", q_value.pop_front(), retire_value);
					check_field("wen", 64'(q_wen.pop_front()), 64'(retire_wen));
					check_field("illegal", 64'(q_illegal.pop_front()), 64'(retire_illegal));
				end
			end
			// retire is always later than acceptance
			if (inst_valid && inst_ready) begin
				q_pc.push_back(exp_pc);
				q_rd.push_back(exp_rd);
				q_value.push_back(exp_value);
				q_wen.push_back(exp_wen);
				q_illegal.push_back(exp_illegal);
			end
		end
		depth = q_pc.size();
	end

endmodule

// File: bench/npc_core_tb.sv
// drives the instruction stream 1 ns after each edge; expected results come from the model below
`timescale 1ns/10ps
`include "npc_settings.svh"

module npc_core_tb import npc_pkg::*; ;

	// instructions per test, for the run limit
	localparam int N_TOTAL = 11 + 10 + 5 + 5 + 300 + 6;
	localparam int LIMIT   = N_TOTAL * 12 + 200;

	logic      clk;
	logic      rst;
	logic      inst_valid;
	logic      inst_ready;
	npc_inst_t inst;
	logic      retire_valid;
	logic      retire_ready;
	npc_pc_t   retire_pc;
	npc_reg_t  retire_rd;
	npc_data_t retire_value;
	logic      retire_wen;
	logic      retire_illegal;

	// expectation for the word on the input
	npc_pc_t   exp_pc;
	npc_reg_t  exp_rd;
	npc_data_t exp_value;
	logic      exp_wen;
	logic      exp_illegal;

	int        test_id;
	int        err_count;
	int        pending;
	int        tb_errs;
	int        tests_failed;
	int        mark;
	int        cycles;
	int        inst_index;
	int        ready_mode;
	npc_data_t model [`NPC_NREGS];

	npc_core i_npc_core (
		.clk            (clk),
		.rst            (rst),
		.inst_valid     (inst_valid),
		.inst_ready     (inst_ready),
		.inst           (inst),
		.retire_valid   (retire_valid),
		.retire_ready   (retire_ready),
		.retire_pc      (retire_pc),
		.retire_rd      (retire_rd),
		.retire_value   (retire_value),
		.retire_wen     (retire_wen),
		.retire_illegal (retire_illegal)
	);

	npc_core_checker i_checker (
		.clk            (clk),
		.rst            (rst),
		.test_id        (test_id),
		.inst_valid     (inst_valid),
		.inst_ready     (inst_ready),
		.exp_pc         (exp_pc),
		.exp_rd         (exp_rd),
		.exp_value      (exp_value),
		.exp_wen        (exp_wen),
		.exp_illegal    (exp_illegal),
		.retire_valid   (retire_valid),
		.retire_ready   (retire_ready),
		.retire_pc      (retire_pc),
		.retire_rd      (retire_rd),
		.retire_value   (retire_value),
		.retire_wen     (retire_wen),
		.retire_illegal (retire_illegal),
		.err_count      (err_count),
		.pending        (pending)
	);

	always #50 clk = ~clk;

	// retire_ready: 0 held high, 1 random, else held low
	always @(posedge clk) begin
		#1;
		if (ready_mode == 0) begin
			retire_ready = 1'b1;
		end else if (ready_mode == 1) begin
			retire_ready = 1'($urandom_range(1, 0));
		end else begin
			retire_ready = 1'b0;
		end
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("ERROR run stopped by timeout after %0d cycles", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ********************
	// reference model
	// ********************

	// executes one word on the register model in program order
	function void exec_ref(input npc_inst_t w, output npc_data_t v, output logic wen,
			output logic ill);
		npc_data_t  a;
		npc_data_t  b;
		npc_data_t  imm;
		logic [6:0] opc;
		logic [6:0] f7;
		logic [2:0] f3;
		opc = w[6:0];
		f3  = w[14:12];
		f7  = w[31:25];
		a   = model[w[19:15]];
		b   = model[w[24:20]];
		imm = {{(`NPC_XLEN-12){w[31]}}, w[31:20]};
		v   = '0;
		wen = 1'b1;
		ill = 1'b0;
		if (opc == 7'h33 && f7 == 7'h00 && f3 == 3'd0) begin
			v = a + b;
		end else if (opc == 7'h33 && f7 == 7'h20 && f3 == 3'd0) begin
			v = a - b;
		end else if (opc == 7'h33 && f7 == 7'h00 && f3 == 3'd7) begin
			v = a & b;
		end else if (opc == 7'h33 && f7 == 7'h00 && f3 == 3'd6) begin
			v = a | b;
		end else if (opc == 7'h33 && f7 == 7'h00 && f3 == 3'd4) begin
			v = a ^ b;
		end else if (opc == 7'h13 && f3 == 3'd0) begin
			v = a + imm;
		end else if (opc == 7'h13 && f3 == 3'd1 && w[31:26] == 6'd0) begin
			v = a << w[25:20];
		end else if (opc == 7'h37) begin
			v = {{(`NPC_XLEN-32){w[31]}}, w[31:12], 12'h000};
		end else begin
			// outside the subset
			wen = 1'b0;
			ill = 1'b1;
		end
	endfunction

	function npc_inst_t rtype_word(input logic [6:0] f7, input logic [2:0] f3,
			input npc_reg_t rd, input npc_reg_t rs1, input npc_reg_t rs2);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function npc_inst_t itype_word(input logic [2:0] f3, input npc_reg_t rd,
			input npc_reg_t rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, 7'h13};
	endfunction

	function npc_inst_t lui_word(input npc_reg_t rd, input logic [19:0] imm);
		return {imm, rd, 7'h37};
	endfunction

	// legal word over x0..x3
	function npc_inst_t random_word();
		npc_reg_t rd;
		npc_reg_t s1;
		npc_reg_t s2;
		int       k;
		rd = npc_reg_t'($urandom_range(3, 0));
		s1 = npc_reg_t'($urandom_range(3, 0));
		s2 = npc_reg_t'($urandom_range(3, 0));
		k  = int'($urandom_range(7, 0));
		case (k)
			0:       return rtype_word(7'h00, 3'd0, rd, s1, s2);
			1:       return rtype_word(7'h20, 3'd0, rd, s1, s2);
			2:       return rtype_word(7'h00, 3'd7, rd, s1, s2);
			3:       return rtype_word(7'h00, 3'd6, rd, s1, s2);
			4:       return rtype_word(7'h00, 3'd4, rd, s1, s2);
			5:       return itype_word(3'd0, rd, s1, 12'($urandom));
			6:       return itype_word(3'd1, rd, s1, {6'd0, 6'($urandom)});
			default: return lui_word(rd, 20'($urandom));
		endcase
	endfunction

	// ********************
	// stimulus helpers
	// ********************

	// called 1 ns after an edge; returns 1 ns after the accepting edge
	task automatic send(input npc_inst_t w);
		npc_data_t v;
		logic      wen;
		logic      ill;
		logic      taken;
		exec_ref(w, v, wen, ill);
		inst        = w;
		inst_valid  = 1'b1;
		exp_pc      = `NPC_RESET_PC + (npc_pc_t'(inst_index) << 2);
		exp_rd      = w[11:7];
		exp_value   = v;
		exp_wen     = wen;
		exp_illegal = ill;
		taken       = 1'b0;
		while (!taken) begin
			// ready is settled by mid cycle
			@(negedge clk);
			taken = inst_ready;
			@(posedge clk);
			#1;
		end
		inst_valid = 1'b0;
		if (wen && w[11:7] != 5'd0) begin
			model[w[11:7]] = v;
		end
		inst_index++;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic clear_model();
		for (int i = 0; i < `NPC_NREGS; i++) begin
			model[i] = '0;
		end
		inst_index = 0;
	endtask

	// up to 300 cycles for the expected queue to empty
	task automatic wait_drain();
		int n;
		n = 0;
		while (pending != 0 && n < 300) begin
			idle(1);
			n++;
		end
	endtask

	// waits for the queue to empty, then prints the test line
	task automatic finish_test(input string name);
		int errs;
		wait_drain();
		if (pending != 0) begin
			$display("ERROR test %s: %0d instructions never retired", name, pending);
			tb_errs += pending;
		end
		errs = err_count + tb_errs - mark;
		mark = err_count + tb_errs;
		if (errs == 0) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: %0d errors", name, errs);
			tests_failed++;
		end
	endtask

	// ********************
	// tests
	// ********************

	initial begin
		int n;
		void'($urandom(32'h448b581f));
		clk          = 1'b0;
		rst          = 1'b1;
		inst_valid   = 1'b0;
		inst         = '0;
		retire_ready = 1'b1;
		exp_pc       = '0;
		exp_rd       = '0;
		exp_value    = '0;
		exp_wen      = 1'b0;
		exp_illegal  = 1'b0;
		test_id      = 0;
		tb_errs      = 0;
		tests_failed = 0;
		mark         = 0;
		cycles       = 0;
		ready_mode   = 0;
		clear_model();
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		// constants, then every alu operation on them
		test_id = 1;
		send(lui_word(5'd1, 20'h12345));
		send(itype_word(3'd0, 5'd1, 5'd1, 12'h678));
		send(lui_word(5'd2, 20'hfedcb));
		send(itype_word(3'd0, 5'd2, 5'd2, 12'h9a5));
		send(rtype_word(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
		send(rtype_word(7'h20, 3'd0, 5'd4, 5'd1, 5'd2));
		send(rtype_word(7'h00, 3'd7, 5'd5, 5'd1, 5'd2));
		send(rtype_word(7'h00, 3'd6, 5'd6, 5'd1, 5'd2));
		send(rtype_word(7'h00, 3'd4, 5'd7, 5'd1, 5'd2));
		send(itype_word(3'd1, 5'd8, 5'd1, 12'd33));
		wait_drain();
		// single instruction into an empty pipeline, accept edge counted as 1
		send(itype_word(3'd0, 5'd9, 5'd0, 12'd1));
		n = 1;
		while (!retire_valid && n < 20) begin
			idle(1);
			n++;
		end
		if (n != 4) begin
			$display("FAIL independent_arith latency expected %0d actual %0d", 4, n);
			tb_errs++;
		end
		finish_test("independent_arith");

		// each one reads the result just before it
		test_id = 2;
		send(itype_word(3'd0, 5'd1, 5'd0, 12'd3));
		repeat (5) send(rtype_word(7'h00, 3'd0, 5'd1, 5'd1, 5'd1));
		send(itype_word(3'd0, 5'd2, 5'd1, 12'hfff));
		send(itype_word(3'd1, 5'd3, 5'd2, 12'd4));
		send(rtype_word(7'h20, 3'd0, 5'd4, 5'd3, 5'd2));
		send(rtype_word(7'h00, 3'd4, 5'd5, 5'd4, 5'd3));
		finish_test("dependency_chain");

		// writes to x0 retire but never land
		test_id = 3;
		send(itype_word(3'd0, 5'd0, 5'd0, 12'd55));
		send(lui_word(5'd0, 20'habcde));
		send(rtype_word(7'h00, 3'd0, 5'd6, 5'd0, 5'd0));
		send(itype_word(3'd0, 5'd7, 5'd0, 12'd9));
		send(rtype_word(7'h00, 3'd6, 5'd8, 5'd0, 5'd7));
		finish_test("register_zero");

		// load, mul and an unknown opcode, then readers of their rd
		test_id = 4;
		send({12'h000, 5'd1, 3'b011, 5'd3, 7'h03});
		send(rtype_word(7'h01, 3'd0, 5'd4, 5'd1, 5'd2));
		send(32'hffff_ffff);
		send(rtype_word(7'h00, 3'd0, 5'd9, 5'd3, 5'd4));
		send(rtype_word(7'h00, 3'd4, 5'd10, 5'd4, 5'd0));
		finish_test("illegal_encoding");

		// random gaps on input, random stalls on retire
		test_id    = 5;
		ready_mode = 1;
		for (int i = 0; i < 300; i++) begin
			if ($urandom_range(2, 0) == 0) begin
				idle(int'($urandom_range(3, 1)));
			end
			send(random_word());
		end
		ready_mode = 0;
		finish_test("random_backpressure");

		// fill the pipeline, hold retire, then reset
		test_id    = 6;
		ready_mode = 2;
		send(itype_word(3'd0, 5'd1, 5'd0, 12'd11));
		send(itype_word(3'd0, 5'd2, 5'd0, 12'd22));
		send(itype_word(3'd0, 5'd3, 5'd0, 12'd33));
		send(itype_word(3'd0, 5'd4, 5'd0, 12'd44));
		rst = 1'b1;
		idle(10);
		clear_model();
		rst        = 1'b0;
		ready_mode = 0;
		if (retire_valid) begin
			$display("ERROR test reset_midstream: retire_valid is high right after reset");
			tb_errs++;
		end
		// pc must restart, registers read zero
		send(itype_word(3'd0, 5'd1, 5'd1, 12'd7));
		send(rtype_word(7'h00, 3'd0, 5'd2, 5'd1, 5'd2));
		finish_test("reset_midstream");

		$display("tests: 6 run, %0d failed, %0d errors", tests_failed, err_count + tb_errs);
		if (tests_failed == 0 && err_count + tb_errs == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: hw/npc_core.sv
// four register stages, four in flight at most; a dependent instruction waits for writeback
`timescale 1ns/10ps
`include "npc_settings.svh"

module npc_core import npc_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// instruction stream
	input  logic      inst_valid,
	output logic      inst_ready,
	input  npc_inst_t inst,
	// retire port
	output logic      retire_valid,
	input  logic      retire_ready,
	output npc_pc_t   retire_pc,
	output npc_reg_t  retire_rd,
	output npc_data_t retire_value,
	output logic      retire_wen,
	output logic      retire_illegal
);

	// fetch to decode
	logic      f_valid;
	logic      f_ready;
	npc_pc_t   f_pc;
	npc_inst_t f_inst;

	// decode to register file
	npc_reg_t  rs1;
	npc_reg_t  rs2;
	npc_data_t rdata1;
	npc_data_t rdata2;
	logic      busy1;
	logic      busy2;
	logic      claim_en;
	npc_reg_t  claim_rd;

	// decode to execute
	logic      d_valid;
	logic      d_ready;
	npc_pc_t   d_pc;
	npc_op_t   d_op;
	npc_reg_t  d_rd;
	logic      d_wen;
	npc_data_t d_src_a;
	npc_data_t d_src_b;
	npc_data_t d_imm;

	// execute to writeback
	logic      e_valid;
	logic      e_ready;
	npc_pc_t   e_pc;
	npc_reg_t  e_rd;
	logic      e_wen;
	logic      e_illegal;
	npc_data_t e_result;

	// writeback to register file
	logic      wr_en;
	npc_reg_t  wr_rd;
	npc_data_t wr_data;

	// ********************
	// stages
	// ********************

	npc_fetch i_fetch (
		.clk        (clk),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_ready (inst_ready),
		.f_valid    (f_valid),
		.f_pc       (f_pc),
		.f_inst     (f_inst),
		.f_ready    (f_ready)
	);

	npc_decode i_decode (
		.clk      (clk),
		.rst      (rst),
		.f_valid  (f_valid),
		.f_pc     (f_pc),
		.f_inst   (f_inst),
		.f_ready  (f_ready),
		.rs1      (rs1),
		.rs2      (rs2),
		.rdata1   (rdata1),
		.rdata2   (rdata2),
		.busy1    (busy1),
		.busy2    (busy2),
		.claim_en (claim_en),
		.claim_rd (claim_rd),
		.d_valid  (d_valid),
		.d_ready  (d_ready),
		.d_pc     (d_pc),
		.d_op     (d_op),
		.d_rd     (d_rd),
		.d_wen    (d_wen),
		.d_src_a  (d_src_a),
		.d_src_b  (d_src_b),
		.d_imm    (d_imm)
	);

	// registers plus scoreboard
	npc_regfile i_regfile (
		.clk      (clk),
		.rst      (rst),
		.rs1      (rs1),
		.rs2      (rs2),
		.rdata1   (rdata1),
		.rdata2   (rdata2),
		.busy1    (busy1),
		.busy2    (busy2),
		.claim_en (claim_en),
		.claim_rd (claim_rd),
		.wr_en    (wr_en),
		.wr_rd    (wr_rd),
		.wr_data  (wr_data)
	);

	npc_execute i_execute (
		.clk       (clk),
		.rst       (rst),
		.d_valid   (d_valid),
		.d_ready   (d_ready),
		.d_pc      (d_pc),
		.d_op      (d_op),
		.d_rd      (d_rd),
		.d_wen     (d_wen),
		.d_src_a   (d_src_a),
		.d_src_b   (d_src_b),
		.d_imm     (d_imm),
		.e_valid   (e_valid),
		.e_ready   (e_ready),
		.e_pc      (e_pc),
		.e_rd      (e_rd),
		.e_wen     (e_wen),
		.e_illegal (e_illegal),
		.e_result  (e_result)
	);

	npc_writeback i_writeback (
		.clk            (clk),
		.rst            (rst),
		.e_valid        (e_valid),
		.e_ready        (e_ready),
		.e_pc           (e_pc),
		.e_rd           (e_rd),
		.e_wen          (e_wen),
		.e_illegal      (e_illegal),
		.e_result       (e_result),
		.retire_valid   (retire_valid),
		.retire_ready   (retire_ready),
		.retire_pc      (retire_pc),
		.retire_rd      (retire_rd),
		.retire_value   (retire_value),
		.retire_wen     (retire_wen),
		.retire_illegal (retire_illegal),
		.wr_en          (wr_en),
		.wr_rd          (wr_rd),
		.wr_data        (wr_data)
	);

endmodule

// File: hw/npc_decode.sv
// subset decode only; a source with a pending write holds the instruction here, no bypassing
`timescale 1ns/10ps
`include "npc_settings.svh"

module npc_decode import npc_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// from fetch
	input  logic      f_valid,
	input  npc_pc_t   f_pc,
	input  npc_inst_t f_inst,
	output logic      f_ready,
	// register file reads
	output npc_reg_t  rs1,
	output npc_reg_t  rs2,
	input  npc_data_t rdata1,
	input  npc_data_t rdata2,
	input  logic      busy1,
	input  logic      busy2,
	// destination claim
	output logic      claim_en,
	output npc_reg_t  claim_rd,
	// issue slot towards execute
	output logic      d_valid,
	input  logic      d_ready,
	output npc_pc_t   d_pc,
	output npc_op_t   d_op,
	output npc_reg_t  d_rd,
	output logic      d_wen,
	output npc_data_t d_src_a,
	output npc_data_t d_src_b,
	output npc_data_t d_imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	npc_reg_t   inst_rd;
	npc_op_t    op;
	npc_data_t  imm_i;
	npc_data_t  imm_u;
	logic       need_rs1;
	logic       need_rs2;
	logic       srcs_free;
	logic       issue;
	logic       wen;

	// ********************
	// fields
	// ********************

	assign opcode  = f_inst[6:0];
	assign inst_rd = f_inst[11:7];
	assign funct3  = f_inst[14:12];
	assign rs1     = f_inst[19:15];
	assign rs2     = f_inst[24:20];
	assign funct7  = f_inst[31:25];

	// sign extended immediates
	assign imm_i = {{(`NPC_XLEN-12){f_inst[31]}}, f_inst[31:20]};
	assign imm_u = {{(`NPC_XLEN-32){f_inst[31]}}, f_inst[31:12], 12'b0};

	// operation decode
	always_comb begin
		op = OP_ILLEGAL;
		case (opcode)
			// op, register-register
			7'b0110011: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000:  op = OP_ADD;
						3'b100:  op = OP_XOR;
						3'b110:  op = OP_OR;
						3'b111:  op = OP_AND;
						default: op = OP_ILLEGAL;
					endcase
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					op = OP_SUB;
				end
			end
			// op-imm; rv64 slli has a 6-bit shamt, funct6 must be zero
			7'b0010011: begin
				if (funct3 == 3'b000) begin
					op = OP_ADDI;
				end else if (funct3 == 3'b001 && f_inst[31:26] == 6'b0) begin
					op = OP_SLLI;
				end
			end
			7'b0110111: op = OP_LUI;
			default:    op = OP_ILLEGAL;
		endcase
	end

	// ********************
	// hazard check
	// ********************

	// lui and illegal read nothing
	assign need_rs1  = (op != OP_LUI) && (op != OP_ILLEGAL);
	// only r-type reads rs2
	assign need_rs2  = (op == OP_ADD) || (op == OP_SUB) || (op == OP_AND)
		|| (op == OP_OR) || (op == OP_XOR);
	assign srcs_free = !(need_rs1 && busy1) && !(need_rs2 && busy2);

	// stalled until writeback frees the source
	assign f_ready = srcs_free && (!d_valid || d_ready);
	assign issue   = f_valid && f_ready;

	// write flag as decoded, x0 included
	assign wen = (op != OP_ILLEGAL);

	// x0 is never claimed
	assign claim_en = issue && wen && (inst_rd != '0);
	assign claim_rd = inst_rd;

	// ********************
	// issue slot
	// ********************

	always_ff @(posedge clk) begin
		if (rst) begin
			d_valid <= 1'b0;
		end else if (issue) begin
			d_valid <= 1'b1;
		end else if (d_ready) begin
			d_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			d_pc    <= f_pc;
			d_op    <= op;
			d_rd    <= inst_rd;
			d_wen   <= wen;
			d_src_a <= rdata1;
			d_src_b <= rdata2;
			// lui carries the upper immediate, all others the i-type one
			d_imm   <= (op == OP_LUI) ? imm_u : imm_i;
		end
	end

endmodule

// File: hw/npc_execute.sv
// single-cycle alu for the subset; illegal operations carry a zero result and no write
`timescale 1ns/10ps
`include "npc_settings.svh"

module npc_execute import npc_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// from decode
	input  logic      d_valid,
	output logic      d_ready,
	input  npc_pc_t   d_pc,
	input  npc_op_t   d_op,
	input  npc_reg_t  d_rd,
	input  logic      d_wen,
	input  npc_data_t d_src_a,
	input  npc_data_t d_src_b,
	input  npc_data_t d_imm,
	// result slot towards writeback
	output logic      e_valid,
	input  logic      e_ready,
	output npc_pc_t   e_pc,
	output npc_reg_t  e_rd,
	output logic      e_wen,
	output logic      e_illegal,
	output npc_data_t e_result
);

	npc_data_t result;
	logic      take;

	assign d_ready = !e_valid || e_ready;
	assign take    = d_valid && d_ready;

	// ********************
	// alu
	// ********************

	always_comb begin
		case (d_op)
			OP_ADD:  result = d_src_a + d_src_b;
			OP_SUB:  result = d_src_a - d_src_b;
			OP_AND:  result = d_src_a & d_src_b;
			OP_OR:   result = d_src_a | d_src_b;
			OP_XOR:  result = d_src_a ^ d_src_b;
			OP_ADDI: result = d_src_a + d_imm;
			// shamt sits in the low six immediate bits
			OP_SLLI: result = d_src_a << d_imm[5:0];
			// already shifted by decode
			OP_LUI:  result = d_imm;
			default: result = '0;
		endcase
	end

	// ********************
	// result slot
	// ********************

	always_ff @(posedge clk) begin
		if (rst) begin
			e_valid <= 1'b0;
		end else if (take) begin
			e_valid <= 1'b1;
		end else if (e_ready) begin
			e_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			e_pc      <= d_pc;
			e_rd      <= d_rd;
			e_wen     <= d_wen;
			e_illegal <= (d_op == OP_ILLEGAL);
			e_result  <= result;
		end
	end

endmodule

// File: hw/npc_fetch.sv
// no fetch memory; instructions come as a stream and the pc only counts up, never redirects
`timescale 1ns/10ps
`include "npc_settings.svh"

module npc_fetch import npc_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// instruction stream in
	input  logic      inst_valid,
	input  npc_inst_t inst,
	output logic      inst_ready,
	// slot towards decode
	output logic      f_valid,
	output npc_pc_t   f_pc,
	output npc_inst_t f_inst,
	input  logic      f_ready
);

	// pc given to the next accepted instruction
	npc_pc_t pc;
	logic    accept;

	// slot empty or draining this cycle
	assign inst_ready = !f_valid || f_ready;
	assign accept     = inst_valid && inst_ready;

	// ********************
	// control
	// ********************

	always_ff @(posedge clk) begin
		if (rst) begin
			f_valid <= 1'b0;
			pc      <= `NPC_RESET_PC;
		end else begin
			if (accept) begin
				f_valid <= 1'b1;
				// one word per instruction
				pc      <= pc + npc_pc_t'(4);
			end else if (f_ready) begin
				f_valid <= 1'b0;
			end
		end
	end

	// ********************
	// payload
	// ********************

	// pc travels with the word it was taken for
	always_ff @(posedge clk) begin
		if (accept) begin
			f_pc   <= pc;
			f_inst <= inst;
		end
	end

endmodule

// File: hw/npc_pkg.sv
// types shared by all stages; widths follow npc_settings.svh and are not meant to change alone
`include "npc_settings.svh"

package npc_pkg;

	// ********************
	// datapath types
	// ********************

	// one register value
	typedef logic [`NPC_XLEN-1:0] npc_data_t;
	// instruction address
	typedef logic [`NPC_XLEN-1:0] npc_pc_t;
	// register index, x0..x31
	typedef logic [4:0] npc_reg_t;
	// raw 32-bit instruction word, no compressed forms
	typedef logic [31:0] npc_inst_t;

	// ********************
	// decoded operation
	// ********************

	// r-type first, then i-type, then u-type
	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_ADDI,
		OP_SLLI,
		OP_LUI,
		// anything outside the subset
		OP_ILLEGAL
	} npc_op_t;

endpackage

// File: hw/npc_regfile.sv
// x0 reads zero; up to three writes per register in flight, more than that wraps the busy count
`timescale 1ns/10ps
`include "npc_settings.svh"

module npc_regfile import npc_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// decode read side
	input  npc_reg_t  rs1,
	input  npc_reg_t  rs2,
	output npc_data_t rdata1,
	output npc_data_t rdata2,
	output logic      busy1,
	output logic      busy2,
	// destination claim at issue
	input  logic      claim_en,
	input  npc_reg_t  claim_rd,
	// writeback side, also releases the claim
	input  logic      wr_en,
	input  npc_reg_t  wr_rd,
	input  npc_data_t wr_data
);

	npc_data_t  regs [`NPC_NREGS];
	// pending writes per register, busy while nonzero
	logic [1:0] pend [`NPC_NREGS];

	// ********************
	// reads
	// ********************

	// state before the edge, no bypass
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];
	assign busy1  = (pend[rs1] != 2'd0);
	assign busy2  = (pend[rs2] != 2'd0);

	// ********************
	// register array
	// ********************

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NPC_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_rd != '0) begin
			regs[wr_rd] <= wr_data;
		end
	end

	// ********************
	// scoreboard
	// ********************

	// claim and release on one register at one edge cancel out,
	// so a younger claim keeps it busy
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NPC_NREGS; i++) begin
				pend[i] <= 2'd0;
			end
		end else begin
			// x0 never counts
			for (int i = 1; i < `NPC_NREGS; i++) begin
				if (claim_en && claim_rd == npc_reg_t'(i)
						&& !(wr_en && wr_rd == npc_reg_t'(i))) begin
					pend[i] <= pend[i] + 2'd1;
				end else if (wr_en && wr_rd == npc_reg_t'(i)
						&& !(claim_en && claim_rd == npc_reg_t'(i))) begin
					pend[i] <= pend[i] - 2'd1;
				end
			end
		end
	end

endmodule

// File: hw/npc_settings.svh
// rv64 only; the reset pc must be word aligned and the register count stays at 32
`ifndef NPC_SETTINGS_SVH
`define NPC_SETTINGS_SVH

// ********************
// datapath widths
// ********************

// integer register and pc width
`define NPC_XLEN 64
// pc of the first accepted instruction
`define NPC_RESET_PC 64'h80000000
// general registers, x0 included
`define NPC_NREGS 32

`endif

// File: hw/npc_writeback.sv
// the register write and busy release happen only on the retire handshake, never before
`timescale 1ns/10ps
`include "npc_settings.svh"

module npc_writeback import npc_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// from execute
	input  logic      e_valid,
	output logic      e_ready,
	input  npc_pc_t   e_pc,
	input  npc_reg_t  e_rd,
	input  logic      e_wen,
	input  logic      e_illegal,
	input  npc_data_t e_result,
	// retire port
	output logic      retire_valid,
	input  logic      retire_ready,
	output npc_pc_t   retire_pc,
	output npc_reg_t  retire_rd,
	output npc_data_t retire_value,
	output logic      retire_wen,
	output logic      retire_illegal,
	// register file write
	output logic      wr_en,
	output npc_reg_t  wr_rd,
	output npc_data_t wr_data
);

	logic take;
	logic retire;

	assign e_ready = !retire_valid || retire_ready;
	assign take    = e_valid && e_ready;
	assign retire  = retire_valid && retire_ready;

	// write lands at the same edge as the handshake
	assign wr_en   = retire && retire_wen;
	assign wr_rd   = retire_rd;
	assign wr_data = retire_value;

	// ********************
	// retire slot
	// ********************

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
		end else if (take) begin
			retire_valid <= 1'b1;
		end else if (retire_ready) begin
			retire_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			retire_pc      <= e_pc;
			retire_rd      <= e_rd;
			retire_value   <= e_result;
			retire_wen     <= e_wen;
			retire_illegal <= e_illegal;
		end
	end

endmodule

// File: npc_core.f
+incdir+hw
hw/npc_pkg.sv
hw/npc_fetch.sv
hw/npc_regfile.sv
hw/npc_decode.sv
hw/npc_execute.sv
hw/npc_writeback.sv
hw/npc_core.sv
bench/npc_core_checker.sv
bench/npc_core_tb.sv
